// ==== verilog/pe_icn_pkg.sv ====
/*
 * Shared widths and the request payload of the PE interconnect port.
 * DATA_WIDTH must be a multiple of 8 so that BE_WIDTH is exact.
 * The master ID is not defined here. Its width is N_CH0 + N_CH1 and
 * follows the module parameters of the top level.
 */

package pe_icn_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    parameter int ADDR_WIDTH = 32;
    parameter int DATA_WIDTH = 32;
    parameter int BE_WIDTH   = DATA_WIDTH / 8;

    // Default population of the two channels
    parameter int N_CH0_DEFAULT = 4;
    parameter int N_CH1_DEFAULT = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Request payload
    ////////////////////////////////////////////////////////////////////////////

    // Fields that travel with a request, without req and ID
    // wen is active low: 0 means write, 1 means read
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] add;
        logic                  wen;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
    } req_payload_t;

endpackage

// ==== verilog/pe_req_if.sv ====
/*
 * One arbitrated request port with its grant.
 * A transfer happens in a cycle where req and gnt are both high.
 * While req is high and gnt is low the master holds payload and id.
 * The slave may hold gnt low for any number of cycles.
 */

`timescale 1ns/1ps

interface pe_req_if #(
    parameter int ID_WIDTH = pe_icn_pkg::N_CH0_DEFAULT + pe_icn_pkg::N_CH1_DEFAULT
);

    logic                     req;
    pe_icn_pkg::req_payload_t payload;
    logic [ID_WIDTH-1:0]      id;
    logic                     gnt;

    // Request source side
    modport master (
        output req,
        output payload,
        output id,
        input  gnt
    );

    // Request sink side
    modport slave (
        input  req,
        input  payload,
        input  id,
        output gnt
    );

endinterface

// ==== verilog/rr_arb_tree.sv ====
/*
 * Round-robin arbitration tree for one channel.
 * N_MASTER must be a power of two and at least 2.
 * Selection and grant return are combinational. The only state is the
 * priority pointer, which advances after each accepted transfer.
 * The root node uses pointer bit 0, so from pointer zero the order for
 * four masters is 0, 2, 1, 3.
 */

`timescale 1ns/1ps

module rr_arb_tree #(
    parameter int N_MASTER = 4,
    parameter int ID_WIDTH = 5
) (
    input  logic                                     clk,
    input  logic                                     rst_n_i,

    input  logic [N_MASTER-1:0]                      req_i,
    input  pe_icn_pkg::req_payload_t [N_MASTER-1:0]  payload_i,
    input  logic [N_MASTER-1:0][ID_WIDTH-1:0]        id_i,
    output logic [N_MASTER-1:0]                      gnt_o,

    pe_req_if.master                                 out
);

    localparam int LOG_MASTER = $clog2(N_MASTER);
    localparam int N_NODES    = 2 * N_MASTER - 1;

    // Heap layout: node 0 is the root, node i has children 2i+1 and 2i+2
    // Leaves sit at N_MASTER-1 .. N_NODES-1
    logic [N_NODES-1:0]         node_req;
    logic [N_NODES-1:0]         node_gnt;
    pe_icn_pkg::req_payload_t   node_pl [N_NODES];
    logic [ID_WIDTH-1:0]        node_id [N_NODES];
    logic [N_MASTER-2:0]        node_sel;

    logic [LOG_MASTER-1:0]      rr_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // Leaves
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_leaf
        assign node_req[N_MASTER-1+m] = req_i[m];
        assign node_pl[N_MASTER-1+m]  = payload_i[m];
        assign node_id[N_MASTER-1+m]  = id_i[m];
        // Never grant a master that does not request
        assign gnt_o[m] = node_gnt[N_MASTER-1+m] & req_i[m];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Select nodes
    ////////////////////////////////////////////////////////////////////////////

    for (genvar d = 0; d < LOG_MASTER; d++)
    begin : g_depth
        for (genvar k = 0; k < 2**d; k++)
        begin : g_node
            localparam int IDX = 2**d - 1 + k;
            localparam int LO  = 2 * IDX + 1;
            localparam int HI  = 2 * IDX + 2;

            // Upper half wins when it is alone or when its pointer bit is set
            assign node_sel[IDX] = node_req[HI] & (~node_req[LO] | rr_ptr[d]);

            assign node_req[IDX] = node_req[LO] | node_req[HI];
            assign node_pl[IDX]  = node_sel[IDX] ? node_pl[HI] : node_pl[LO];
            assign node_id[IDX]  = node_sel[IDX] ? node_id[HI] : node_id[LO];

            // Grant is steered back along the winning path only
            assign node_gnt[LO] = node_gnt[IDX] & ~node_sel[IDX];
            assign node_gnt[HI] = node_gnt[IDX] &  node_sel[IDX];
        end
    end

    // Root to the channel port
    assign out.req     = node_req[0];
    assign out.payload = node_pl[0];
    assign out.id      = node_id[0];
    assign node_gnt[0] = out.gnt;

    ////////////////////////////////////////////////////////////////////////////
    // Priority pointer
    ////////////////////////////////////////////////////////////////////////////

    // Counts 0 .. N_MASTER-1 and wraps on its own width
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rr_ptr <= '0;
        end
        else if (out.req && out.gnt)
        begin
            rr_ptr <= rr_ptr + 1'b1;
        end
    end

endmodule

// ==== verilog/channel_mux2.sv ====
/*
 * Mixer between the channel 0 and channel 1 winners.
 * Selection and grant return are combinational.
 * A one-bit flag decides ties and toggles after every accepted transfer.
 * Both channel ports must carry IDs of width N_CH0 + N_CH1.
 */

`timescale 1ns/1ps

module channel_mux2 #(
    parameter int N_CH0 = 4,
    parameter int N_CH1 = 1
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,

    pe_req_if.slave                              ch0,
    pe_req_if.slave                              ch1,

    // Memory port
    output logic                                 data_req_o,
    output logic [pe_icn_pkg::ADDR_WIDTH-1:0]    data_add_o,
    output logic                                 data_wen_o,
    output logic [pe_icn_pkg::DATA_WIDTH-1:0]    data_wdata_o,
    output logic [pe_icn_pkg::BE_WIDTH-1:0]      data_be_o,
    output logic [N_CH0+N_CH1-1:0]               data_id_o,
    input  logic                                 data_gnt_i
);

    localparam int ID_WIDTH = N_CH0 + N_CH1;

    logic                     rr_flag;
    logic                     sel_ch1;
    pe_icn_pkg::req_payload_t win_payload;
    logic [ID_WIDTH-1:0]      win_id;

    ////////////////////////////////////////////////////////////////////////////
    // Selection
    ////////////////////////////////////////////////////////////////////////////

    // Channel 1 wins alone, or on a tie when the flag is set
    assign sel_ch1 = ch1.req & (~ch0.req | rr_flag);

    assign win_payload = sel_ch1 ? ch1.payload : ch0.payload;
    assign win_id      = sel_ch1 ? ch1.id      : ch0.id;

    assign data_req_o   = ch0.req | ch1.req;
    assign data_add_o   = win_payload.add;
    assign data_wen_o   = win_payload.wen;
    assign data_wdata_o = win_payload.wdata;
    assign data_be_o    = win_payload.be;
    assign data_id_o    = win_id;

    // Memory grant goes back to the selected channel only
    assign ch0.gnt = data_gnt_i & ch0.req & ~sel_ch1;
    assign ch1.gnt = data_gnt_i & sel_ch1;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rr_flag <= 1'b0;
        end
        else if (data_req_o && data_gnt_i)
        begin
            rr_flag <= ~rr_flag;
        end
    end

endmodule

// ==== verilog/resp_decoder.sv ====
/*
 * Response valid decoder.
 * data_r_id_i is expected one-hot, one bit per master with channel 0
 * first. A zero or multi-hot ID is passed through as it is.
 */

`timescale 1ns/1ps

module resp_decoder #(
    parameter int N_MASTER = 5
) (
    input  logic                data_r_valid_i,
    input  logic [N_MASTER-1:0] data_r_id_i,
    output logic [N_MASTER-1:0] data_r_valid_o
);

    // One strobe per master, qualified by the response valid
    always_comb
    begin
        for (int k = 0; k < N_MASTER; k++)
        begin
            data_r_valid_o[k] = data_r_valid_i & data_r_id_i[k];
        end
    end

endmodule

// ==== verilog/pe_request_block.sv ====
/*
 * Request side of a PE interconnect port serving one memory bank.
 * N_CH0 and N_CH1 must be powers of two, N_CH0 >= 2 and N_CH1 >= 1.
 * Each master supplies its own one-hot ID of width N_CH0 + N_CH1,
 * channel 0 in the low bits. Request and grant paths are combinational.
 */

`timescale 1ns/1ps

module pe_request_block #(
    parameter int N_CH0 = pe_icn_pkg::N_CH0_DEFAULT,
    parameter int N_CH1 = pe_icn_pkg::N_CH1_DEFAULT
) (
    input  logic                                        clk,
    input  logic                                        rst_n_i,

    // Channel 0, cores
    input  logic [N_CH0-1:0]                            data_req_ch0_i,
    input  logic [N_CH0-1:0][pe_icn_pkg::ADDR_WIDTH-1:0] data_add_ch0_i,
    input  logic [N_CH0-1:0]                            data_wen_ch0_i,
    input  logic [N_CH0-1:0][pe_icn_pkg::DATA_WIDTH-1:0] data_wdata_ch0_i,
    input  logic [N_CH0-1:0][pe_icn_pkg::BE_WIDTH-1:0]   data_be_ch0_i,
    input  logic [N_CH0-1:0][N_CH0+N_CH1-1:0]            data_id_ch0_i,
    output logic [N_CH0-1:0]                            data_gnt_ch0_o,

    // Channel 1, DMA ports
    input  logic [N_CH1-1:0]                            data_req_ch1_i,
    input  logic [N_CH1-1:0][pe_icn_pkg::ADDR_WIDTH-1:0] data_add_ch1_i,
    input  logic [N_CH1-1:0]                            data_wen_ch1_i,
    input  logic [N_CH1-1:0][pe_icn_pkg::DATA_WIDTH-1:0] data_wdata_ch1_i,
    input  logic [N_CH1-1:0][pe_icn_pkg::BE_WIDTH-1:0]   data_be_ch1_i,
    input  logic [N_CH1-1:0][N_CH0+N_CH1-1:0]            data_id_ch1_i,
    output logic [N_CH1-1:0]                            data_gnt_ch1_o,

    // Memory port
    output logic                                        data_req_o,
    output logic [pe_icn_pkg::ADDR_WIDTH-1:0]           data_add_o,
    output logic                                        data_wen_o,
    output logic [pe_icn_pkg::DATA_WIDTH-1:0]           data_wdata_o,
    output logic [pe_icn_pkg::BE_WIDTH-1:0]             data_be_o,
    output logic [N_CH0+N_CH1-1:0]                      data_id_o,
    input  logic                                        data_gnt_i,
    input  logic                                        data_r_valid_i,
    input  logic [N_CH0+N_CH1-1:0]                      data_r_id_i,

    // Response strobes
    output logic [N_CH0-1:0]                            data_r_valid_ch0_o,
    output logic [N_CH1-1:0]                            data_r_valid_ch1_o
);

    localparam int ID_WIDTH = N_CH0 + N_CH1;

    pe_icn_pkg::req_payload_t [N_CH0-1:0] ch0_payload;
    pe_icn_pkg::req_payload_t [N_CH1-1:0] ch1_payload;
    logic [ID_WIDTH-1:0]                  r_valid;

    // Channel winners
    pe_req_if #(.ID_WIDTH(ID_WIDTH)) ch0_win ();
    pe_req_if #(.ID_WIDTH(ID_WIDTH)) ch1_win ();

    ////////////////////////////////////////////////////////////////////////////
    // Payload packing
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < N_CH0; m++)
    begin : g_pack_ch0
        assign ch0_payload[m] = '{add:   data_add_ch0_i[m],
                                  wen:   data_wen_ch0_i[m],
                                  wdata: data_wdata_ch0_i[m],
                                  be:    data_be_ch0_i[m]};
    end

    for (genvar m = 0; m < N_CH1; m++)
    begin : g_pack_ch1
        assign ch1_payload[m] = '{add:   data_add_ch1_i[m],
                                  wen:   data_wen_ch1_i[m],
                                  wdata: data_wdata_ch1_i[m],
                                  be:    data_be_ch1_i[m]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-channel arbitration
    ////////////////////////////////////////////////////////////////////////////

    if (N_CH0 > 1)
    begin : g_ch0_tree
        rr_arb_tree #(
            .N_MASTER (N_CH0),
            .ID_WIDTH (ID_WIDTH)
        ) i_ch0_tree (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .req_i     (data_req_ch0_i),
            .payload_i (ch0_payload),
            .id_i      (data_id_ch0_i),
            .gnt_o     (data_gnt_ch0_o),
            .out       (ch0_win)
        );
    end
    else
    begin : g_ch0_direct
        assign ch0_win.req     = data_req_ch0_i[0];
        assign ch0_win.payload = ch0_payload[0];
        assign ch0_win.id      = data_id_ch0_i[0];
        assign data_gnt_ch0_o  = ch0_win.gnt;
    end

    if (N_CH1 > 1)
    begin : g_ch1_tree
        rr_arb_tree #(
            .N_MASTER (N_CH1),
            .ID_WIDTH (ID_WIDTH)
        ) i_ch1_tree (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .req_i     (data_req_ch1_i),
            .payload_i (ch1_payload),
            .id_i      (data_id_ch1_i),
            .gnt_o     (data_gnt_ch1_o),
            .out       (ch1_win)
        );
    end
    else
    begin : g_ch1_direct
        // Single DMA port goes straight to the mixer
        assign ch1_win.req     = data_req_ch1_i[0];
        assign ch1_win.payload = ch1_payload[0];
        assign ch1_win.id      = data_id_ch1_i[0];
        assign data_gnt_ch1_o  = ch1_win.gnt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Channel mixing and response decode
    ////////////////////////////////////////////////////////////////////////////

    channel_mux2 #(
        .N_CH0 (N_CH0),
        .N_CH1 (N_CH1)
    ) i_channel_mux2 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ch0          (ch0_win),
        .ch1          (ch1_win),
        .data_req_o   (data_req_o),
        .data_add_o   (data_add_o),
        .data_wen_o   (data_wen_o),
        .data_wdata_o (data_wdata_o),
        .data_be_o    (data_be_o),
        .data_id_o    (data_id_o),
        .data_gnt_i   (data_gnt_i)
    );

    resp_decoder #(
        .N_MASTER (ID_WIDTH)
    ) i_resp_decoder (
        .data_r_valid_i (data_r_valid_i),
        .data_r_id_i    (data_r_id_i),
        .data_r_valid_o (r_valid)
    );

    // Channel 0 owns the low ID bits
    assign data_r_valid_ch0_o = r_valid[N_CH0-1:0];
    assign data_r_valid_ch1_o = r_valid[ID_WIDTH-1:N_CH0];

endmodule

// ==== verif/tb_clk_gen.sv ====
/*
 * Free-running testbench clock and power-on reset.
 * Reset is low for RST_CYCLES rising edges and is released 1 ns after
 * the last of them, in step with the stimulus drive point.
 */

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial
    begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== verif/pe_request_block_checker.sv ====
/*
 * Grant and response legality of pe_request_block, attached with bind.
 * Properties are sampled on the rising clock edge and are off in reset.
 * The strobe property only holds for one-hot or zero response IDs.
 */

`timescale 1ns/1ps

module pe_request_block_checker #(
    parameter int N_CH0 = 4,
    parameter int N_CH1 = 1
) (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic [N_CH0-1:0]       req_ch0_i,
    input logic [N_CH1-1:0]       req_ch1_i,
    input logic [N_CH0-1:0]       gnt_ch0_i,
    input logic [N_CH1-1:0]       gnt_ch1_i,
    input logic                   mem_req_i,
    input logic                   mem_gnt_i,
    input logic [N_CH0+N_CH1-1:0] r_id_i,
    input logic [N_CH0-1:0]       r_strobe_ch0_i,
    input logic [N_CH1-1:0]       r_strobe_ch1_i
);

    localparam int ID_WIDTH = N_CH0 + N_CH1;

    logic [ID_WIDTH-1:0] all_req;
    logic [ID_WIDTH-1:0] all_gnt;
    logic [ID_WIDTH-1:0] all_strobe;

    // Failed assertions so far
    int unsigned fail_count = 0;

    // Channel 0 in the low bits, as in the ID numbering
    assign all_req    = {req_ch1_i, req_ch0_i};
    assign all_gnt    = {gnt_ch1_i, gnt_ch0_i};
    assign all_strobe = {r_strobe_ch1_i, r_strobe_ch0_i};

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(all_gnt))
        else
        begin
            $error("More than one master holds a grant");
            fail_count++;
        end

    a_gnt_needs_mem_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|all_gnt) |-> mem_gnt_i)
        else
        begin
            $error("Master grant without a memory grant");
            fail_count++;
        end

    a_req_iff_any: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i == (|all_req))
        else
        begin
            $error("Memory request does not match the master requests");
            fail_count++;
        end

    a_strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(r_id_i) |-> $onehot0(all_strobe))
        else
        begin
            $error("Several response strobes for a one-hot ID");
            fail_count++;
        end

endmodule

// ==== verif/tb_pe_request_block.sv ====
/*
 * Trace-driven testbench of pe_request_block with 4 cores and 1 DMA port.
 * Each trace line is one cycle. Inputs change 1 ns after the rising edge,
 * outputs are compared 1 ns before the next one. Payload fields are
 * random and are redrawn only on lines that ask for it.
 */

`timescale 1ns/1ps

module tb_pe_request_block;

    localparam int    N_CH0       = 4;
    localparam int    N_CH1       = 1;
    localparam int    ID_WIDTH    = N_CH0 + N_CH1;
    localparam int    RST_TIMEOUT = 64;
    localparam int    MAX_LINES   = 500;
    localparam string TRACE_FILE  = "verif/pe_request_block_trace.txt";

    logic clk;
    logic rst_n;

    logic [N_CH0-1:0]                              data_req_ch0_i;
    logic [N_CH0-1:0][pe_icn_pkg::ADDR_WIDTH-1:0]  data_add_ch0_i;
    logic [N_CH0-1:0]                              data_wen_ch0_i;
    logic [N_CH0-1:0][pe_icn_pkg::DATA_WIDTH-1:0]  data_wdata_ch0_i;
    logic [N_CH0-1:0][pe_icn_pkg::BE_WIDTH-1:0]    data_be_ch0_i;
    logic [N_CH0-1:0][ID_WIDTH-1:0]                data_id_ch0_i;
    logic [N_CH0-1:0]                              data_gnt_ch0_o;
    logic [N_CH1-1:0]                              data_req_ch1_i;
    logic [N_CH1-1:0][pe_icn_pkg::ADDR_WIDTH-1:0]  data_add_ch1_i;
    logic [N_CH1-1:0]                              data_wen_ch1_i;
    logic [N_CH1-1:0][pe_icn_pkg::DATA_WIDTH-1:0]  data_wdata_ch1_i;
    logic [N_CH1-1:0][pe_icn_pkg::BE_WIDTH-1:0]    data_be_ch1_i;
    logic [N_CH1-1:0][ID_WIDTH-1:0]                data_id_ch1_i;
    logic [N_CH1-1:0]                              data_gnt_ch1_o;
    logic                                          data_req_o;
    logic [pe_icn_pkg::ADDR_WIDTH-1:0]             data_add_o;
    logic                                          data_wen_o;
    logic [pe_icn_pkg::DATA_WIDTH-1:0]             data_wdata_o;
    logic [pe_icn_pkg::BE_WIDTH-1:0]               data_be_o;
    logic [ID_WIDTH-1:0]                           data_id_o;
    logic                                          data_gnt_i;
    logic                                          data_r_valid_i;
    logic [ID_WIDTH-1:0]                           data_r_id_i;
    logic [N_CH0-1:0]                              data_r_valid_ch0_o;
    logic [N_CH1-1:0]                              data_r_valid_ch1_o;

    // Fields each master currently presents, channel 0 first
    pe_icn_pkg::req_payload_t master_pl [ID_WIDTH];

    tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(16)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    pe_request_block #(.N_CH0(N_CH0), .N_CH1(N_CH1)) UUT (
        .clk(clk), .rst_n_i(rst_n),
        .data_req_ch0_i(data_req_ch0_i), .data_add_ch0_i(data_add_ch0_i),
        .data_wen_ch0_i(data_wen_ch0_i), .data_wdata_ch0_i(data_wdata_ch0_i),
        .data_be_ch0_i(data_be_ch0_i), .data_id_ch0_i(data_id_ch0_i),
        .data_gnt_ch0_o(data_gnt_ch0_o),
        .data_req_ch1_i(data_req_ch1_i), .data_add_ch1_i(data_add_ch1_i),
        .data_wen_ch1_i(data_wen_ch1_i), .data_wdata_ch1_i(data_wdata_ch1_i),
        .data_be_ch1_i(data_be_ch1_i), .data_id_ch1_i(data_id_ch1_i),
        .data_gnt_ch1_o(data_gnt_ch1_o),
        .data_req_o(data_req_o), .data_add_o(data_add_o), .data_wen_o(data_wen_o),
        .data_wdata_o(data_wdata_o), .data_be_o(data_be_o), .data_id_o(data_id_o),
        .data_gnt_i(data_gnt_i), .data_r_valid_i(data_r_valid_i), .data_r_id_i(data_r_id_i),
        .data_r_valid_ch0_o(data_r_valid_ch0_o), .data_r_valid_ch1_o(data_r_valid_ch1_o)
    );

    bind pe_request_block pe_request_block_checker #(.N_CH0(N_CH0), .N_CH1(N_CH1)) i_checker (
        .clk_i(clk), .rst_n_i(rst_n_i),
        .req_ch0_i(data_req_ch0_i), .req_ch1_i(data_req_ch1_i),
        .gnt_ch0_i(data_gnt_ch0_o), .gnt_ch1_i(data_gnt_ch1_o),
        .mem_req_i(data_req_o), .mem_gnt_i(data_gnt_i), .r_id_i(data_r_id_i),
        .r_strobe_ch0_i(data_r_valid_ch0_o), .r_strobe_ch1_i(data_r_valid_ch1_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure report and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // The bound checker counts its failed assertions
    task automatic stop_on_assertion();
        if (UUT.i_checker.fail_count != 0)
        begin
            fail_run($sformatf("An assertion of the bound checker failed before %0.1f ns",
                               $realtime));
        end
    endtask

    task automatic check_req(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            fail_run($sformatf("Mismatch at %0.1f ns: %s expected %b, got %b",
                               $realtime, name, exp, act));
        end
    endtask

    task automatic check_payload(input string name, input pe_icn_pkg::req_payload_t exp,
                                 input pe_icn_pkg::req_payload_t act);
        if (act !== exp)
        begin
            fail_run($sformatf("Mismatch at %0.1f ns: %s expected %h, got %h",
                               $realtime, name, exp, act));
        end
    endtask

    task automatic check_id(input string name, input logic [ID_WIDTH-1:0] exp,
                            input logic [ID_WIDTH-1:0] act);
        if (act !== exp)
        begin
            fail_run($sformatf("Mismatch at %0.1f ns: %s expected %b, got %b",
                               $realtime, name, exp, act));
        end
    endtask

    // Grant vectors and response strobes share this shape
    task automatic check_valid(input string name, input logic [ID_WIDTH-1:0] exp,
                               input logic [ID_WIDTH-1:0] act);
        if (act !== exp)
        begin
            fail_run($sformatf("Mismatch at %0.1f ns: %s expected %b, got %b",
                               $realtime, name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Position of the single set bit of a one-hot ID
    function automatic int owner_of(input logic [ID_WIDTH-1:0] id);
        int pos;
        pos = 0;
        for (int k = 0; k < ID_WIDTH; k++)
        begin
            if (id[k])
            begin
                pos = k;
            end
        end
        return pos;
    endfunction

    task automatic drive_cycle(input logic [ID_WIDTH-1:0] req, input logic new_pl,
                               input logic gnt, input logic rv,
                               input logic [ID_WIDTH-1:0] rid);
        logic [31:0] rnd;
        if (new_pl)
        begin
            for (int m = 0; m < ID_WIDTH; m++)
            begin
                rnd = $urandom();
                master_pl[m].add   = $urandom();
                master_pl[m].wdata = $urandom();
                master_pl[m].wen   = rnd[0];
                master_pl[m].be    = rnd[pe_icn_pkg::BE_WIDTH:1];
            end
        end
        for (int m = 0; m < N_CH0; m++)
        begin
            data_add_ch0_i[m]   = master_pl[m].add;
            data_wen_ch0_i[m]   = master_pl[m].wen;
            data_wdata_ch0_i[m] = master_pl[m].wdata;
            data_be_ch0_i[m]    = master_pl[m].be;
            data_id_ch0_i[m]    = ID_WIDTH'(1) << m;
        end
        for (int m = 0; m < N_CH1; m++)
        begin
            data_add_ch1_i[m]   = master_pl[N_CH0+m].add;
            data_wen_ch1_i[m]   = master_pl[N_CH0+m].wen;
            data_wdata_ch1_i[m] = master_pl[N_CH0+m].wdata;
            data_be_ch1_i[m]    = master_pl[N_CH0+m].be;
            data_id_ch1_i[m]    = ID_WIDTH'(1) << (N_CH0 + m);
        end
        data_req_ch0_i = req[N_CH0-1:0];
        data_req_ch1_i = req[ID_WIDTH-1:N_CH0];
        data_gnt_i     = gnt;
        data_r_valid_i = rv;
        data_r_id_i    = rid;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int                       fd;
        int                       n;
        int                       iter;
        int                       vec;
        string                    line;
        logic [ID_WIDTH-1:0]      t_req;
        logic [ID_WIDTH-1:0]      t_rid;
        logic [ID_WIDTH-1:0]      e_id;
        logic [ID_WIDTH-1:0]      e_gnt;
        logic [ID_WIDTH-1:0]      e_rv;
        logic                     t_new;
        logic                     t_gnt;
        logic                     t_rv;
        logic                     e_req;
        pe_icn_pkg::req_payload_t act_pl;

        void'($urandom(32'h6888_d4c0));
        for (int m = 0; m < ID_WIDTH; m++)
        begin
            master_pl[m] = '0;
        end
        drive_cycle('0, 1'b0, 1'b0, 1'b0, '0);

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            fail_run({"Could not open the trace file ", TRACE_FILE});
        end

        iter = 0;
        while (rst_n !== 1'b1 && iter < RST_TIMEOUT)
        begin
            @(posedge clk);
            iter++;
        end
        if (rst_n !== 1'b1)
        begin
            fail_run("Reset was not released in time");
        end

        vec  = 0;
        iter = 0;
        while (!$feof(fd) && iter < MAX_LINES)
        begin
            iter++;
            line = "";
            n = $fgets(line, fd);
            // Comment lines start with a hash, blank lines are skipped
            if (n > 0 && line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            t_req, t_new, t_gnt, t_rv, t_rid, e_req, e_id, e_gnt, e_rv);
                if (n != 9)
                begin
                    fail_run($sformatf("Trace line %0d has %0d fields instead of 9", iter, n));
                end
                @(posedge clk);
                #1;
                stop_on_assertion();
                drive_cycle(t_req, t_new, t_gnt, t_rv, t_rid);
                #6;
                act_pl = '{add: data_add_o, wen: data_wen_o, wdata: data_wdata_o,
                           be: data_be_o};
                check_req($sformatf("data_req_o (vector %0d)", vec), e_req, data_req_o);
                if (e_req)
                begin
                    check_id($sformatf("data_id_o (vector %0d)", vec), e_id, data_id_o);
                    check_payload($sformatf("memory payload (vector %0d)", vec),
                                  master_pl[owner_of(e_id)], act_pl);
                end
                check_valid($sformatf("master grants (vector %0d)", vec), e_gnt,
                            {data_gnt_ch1_o, data_gnt_ch0_o});
                check_valid($sformatf("response strobes (vector %0d)", vec), e_rv,
                            {data_r_valid_ch1_o, data_r_valid_ch0_o});
                vec++;
            end
        end
        if (!$feof(fd))
        begin
            fail_run("The trace did not end within the line limit");
        end
        $fclose(fd);

        // Let the checker sample the last vector
        @(posedge clk);
        #1;
        stop_on_assertion();

        if (vec > 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            fail_run("The trace held no vectors");
        end
    end

endmodule

// ==== pe_request_block.f ====
verilog/pe_icn_pkg.sv
verilog/pe_req_if.sv
verilog/rr_arb_tree.sv
verilog/channel_mux2.sv
verilog/resp_decoder.sv
verilog/pe_request_block.sv
verif/tb_clk_gen.sv
verif/pe_request_block_checker.sv
verif/tb_pe_request_block.sv

// ==== verif/pe_request_block_trace.txt ====
# req new_pl gnt r_valid r_id | exp_req exp_id exp_gnt exp_r_valid  (hex, one cycle per line)
# master bits: cores 0..3 in bits 0..3, DMA in bit 4; new_pl 1 draws fresh payloads
00 1 0 1 04  0 00 00 04
00 0 1 1 10  0 00 00 10
00 0 0 0 02  0 00 00 00
04 1 1 0 00  1 04 04 00
01 1 1 1 01  1 01 01 01
08 1 1 0 00  1 08 08 00
02 1 1 1 02  1 02 02 02
0f 1 1 0 00  1 01 01 00
0f 1 1 0 00  1 04 04 00
0f 1 1 1 08  1 02 02 08
0f 1 1 0 00  1 08 08 00
0f 1 1 0 00  1 01 01 00
0f 1 0 0 00  1 04 00 00
0f 0 0 1 10  1 04 00 10
0f 0 0 0 00  1 04 00 00
0f 0 1 0 00  1 04 04 00
0f 1 1 0 00  1 02 02 00
1f 1 1 0 00  1 10 10 00
1f 1 1 1 04  1 08 08 04
1f 1 1 0 00  1 10 10 00
1f 1 1 0 00  1 01 01 00
1f 1 1 0 00  1 10 10 00
1f 1 1 0 00  1 04 04 00
1f 1 0 0 00  1 10 00 00
1f 0 1 0 00  1 10 10 00
1f 1 1 0 00  1 02 02 00
